// File: files.f
rtl/boot_pkg.sv
rtl/boot_arbiter.sv
rtl/flash_array.sv
rtl/boot_read_format.sv
rtl/boot_flash_top.sv
testbench/boot_checker.sv
testbench/tb_boot_flash.sv

// File: rtl/boot_arbiter.sv
`timescale 1ns/1ps

module boot_arbiter (
    input  logic                 sys,
    input  logic                 reset,
    input  logic                 console_request,
    input  logic [31:0]          console_address,
    input  logic                 cpu_request,
    input  logic                 cpu_write,
    input  logic [31:0]          cpu_address,
    input  logic [31:0]          cpu_wdata,
    input  logic                 flash_ack,
    output logic                 flash_request,
    output logic                 flash_write,
    output logic [31:0]          flash_address,
    output logic [31:0]          flash_wdata,
    output boot_pkg::owner_t     owner
);

    localparam logic state_idle = 1'b0;
    localparam logic state_wait = 1'b1;

    logic state;

    assign flash_request = (state == state_wait); // Held for the whole access

    always_ff @(posedge sys) begin
        if (reset) begin
            state <= state_idle;
            owner <= boot_pkg::owner_console;
        end else begin
            case (state)
                state_idle: begin
                    if (console_request) begin
                        state <= state_wait;
                        owner <= boot_pkg::owner_console; // Console has priority
                    end else if (cpu_request) begin
                        state <= state_wait;
                        owner <= boot_pkg::owner_cpu;
                    end
                end
                state_wait: begin
                    if (flash_ack) begin
                        state <= state_idle; // Free for a new request next cycle
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // Command latch, loaded only while idle so it stays stable during the access
    always_ff @(posedge sys) begin
        if (state == state_idle) begin
            if (console_request) begin
                flash_write <= 1'b0; // The console only reads
                flash_address <= console_address;
                flash_wdata <= '0;
            end else if (cpu_request) begin
                flash_write <= cpu_write;
                flash_address <= cpu_address;
                flash_wdata <= cpu_wdata;
            end
        end
    end

endmodule

// File: rtl/boot_flash_top.sv
`timescale 1ns/1ps

module boot_flash_top #(
    parameter int          depth_words = 1024,
    parameter logic [31:0] boot_window = 32'h0001_0000
) (
    input  logic        sys,
    input  logic        reset,
    input  logic        console_request,
    input  logic [31:0] console_address,
    output logic        console_ack,
    output logic [15:0] console_rdata,
    input  logic        cpu_request,
    input  logic        cpu_write,
    input  logic [31:0] cpu_address,
    input  logic [31:0] cpu_wdata,
    output logic        cpu_ack,
    output logic [31:0] cpu_rdata,
    input  logic        erase_start,
    output logic        erase_busy,
    input  logic        wp_enable,
    input  logic        wp_disable
);

    logic                  flash_request;
    logic                  flash_write;
    logic [31:0]           flash_address;
    logic [31:0]           flash_wdata;
    logic                  flash_ack;
    boot_pkg::flash_word_t flash_rdata;
    boot_pkg::owner_t      owner;

    boot_arbiter arbiter_i (
        .sys             (sys),
        .reset           (reset),
        .console_request (console_request),
        .console_address (console_address),
        .cpu_request     (cpu_request),
        .cpu_write       (cpu_write),
        .cpu_address     (cpu_address),
        .cpu_wdata       (cpu_wdata),
        .flash_ack       (flash_ack),
        .flash_request   (flash_request),
        .flash_write     (flash_write),
        .flash_address   (flash_address),
        .flash_wdata     (flash_wdata),
        .owner           (owner)
    );

    flash_array #(
        .depth_words (depth_words)
    ) flash_i (
        .sys         (sys),
        .reset       (reset),
        .erase_start (erase_start),
        .wp_enable   (wp_enable),
        .wp_disable  (wp_disable),
        .request     (flash_request),
        .write       (flash_write),
        .address     (flash_address),
        .wdata       (flash_wdata),
        .erase_busy  (erase_busy),
        .ack         (flash_ack),
        .rdata       (flash_rdata)
    );

    boot_read_format #(
        .boot_window (boot_window)
    ) format_i (
        .ack             (flash_ack),
        .owner           (owner),
        .rdata           (flash_rdata),
        .console_address (console_address),
        .console_ack     (console_ack),
        .console_rdata   (console_rdata),
        .cpu_ack         (cpu_ack),
        .cpu_rdata       (cpu_rdata)
    );

endmodule

// File: rtl/boot_pkg.sv
package boot_pkg;

    // A flash word is read whole by the CPU and as two halfwords by the console
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half; // Index 1 holds bits 31 to 16
    } flash_word_t;

    // Requester that the access in flight belongs to
    typedef enum logic [0:0] {
        owner_console,
        owner_cpu
    } owner_t;

    localparam logic [31:0] erased_word = 32'hffff_ffff; // Every word after an erase

endpackage

// File: rtl/boot_read_format.sv
`timescale 1ns/1ps

module boot_read_format #(
    parameter logic [31:0] boot_window = 32'h0001_0000
) (
    input  logic                  ack,
    input  boot_pkg::owner_t      owner,
    input  boot_pkg::flash_word_t rdata,
    input  logic [31:0]           console_address,
    output logic                  console_ack,
    output logic [15:0]           console_rdata,
    output logic                  cpu_ack,
    output logic [31:0]           cpu_rdata
);

    logic [15:0] console_half;

    always_comb begin
        console_ack = ack && (owner == boot_pkg::owner_console);
        cpu_ack = ack && (owner == boot_pkg::owner_cpu);

        console_half = rdata.half[console_address[1]]; // Address bit 1 picks the halfword
        console_rdata = '0; // Outside the window the console reads zero
        if (console_ack && (console_address < boot_window)) begin
            console_rdata = {console_half[7:0], console_half[15:8]}; // Console is big endian
        end

        cpu_rdata = cpu_ack ? rdata.word : '0;
    end

endmodule

// File: rtl/flash_array.sv
`timescale 1ns/1ps

module flash_array #(
    parameter int depth_words = 1024
) (
    input  logic                  sys,
    input  logic                  reset,
    input  logic                  erase_start,
    input  logic                  wp_enable,
    input  logic                  wp_disable,
    input  logic                  request,
    input  logic                  write,
    input  logic [31:0]           address,
    input  logic [31:0]           wdata,
    output logic                  erase_busy,
    output logic                  ack,
    output boot_pkg::flash_word_t rdata
);

    localparam int index_bits = $clog2(depth_words);

    logic [31:0]           mem [depth_words];
    logic [index_bits-1:0] word_index;
    logic [index_bits-1:0] erase_index;
    logic                  access_step;
    logic                  write_protect;
    logic                  start_access;
    logic                  finish_access;

    // Byte address to word index, wrapping at the array size
    assign word_index = index_bits'((address >> 2) % depth_words);

    // A new access never starts on the ack cycle, the request is still high then
    assign start_access = request && !ack && !erase_busy && !access_step;
    assign finish_access = access_step;

    always_ff @(posedge sys) begin
        if (reset) begin
            access_step <= 1'b0;
            ack <= 1'b0;
            erase_busy <= 1'b0;
            erase_index <= '0;
            write_protect <= 1'b1; // Protected out of reset
        end else begin
            access_step <= start_access;
            ack <= finish_access; // Two cycles after the request is first seen

            if (erase_busy) begin
                erase_index <= erase_index + 1'b1;
                if (erase_index == index_bits'(depth_words - 1)) begin
                    erase_busy <= 1'b0; // Sweep done after depth_words cycles
                end
            end else if (erase_start) begin
                erase_busy <= 1'b1;
                erase_index <= '0;
            end

            if (wp_enable) begin
                write_protect <= 1'b1;
            end else if (wp_disable) begin
                write_protect <= 1'b0;
            end
        end
    end

    // The erase sweep clears one word per cycle
    always_ff @(posedge sys) begin
        if (erase_busy) begin
            mem[erase_index] <= boot_pkg::erased_word;
        end else if (finish_access && write && !write_protect) begin
            mem[word_index] <= wdata; // Protected writes are acked but dropped
        end
    end

    always_ff @(posedge sys) begin
        if (finish_access) begin
            rdata.word <= mem[word_index];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Builds the boot flash testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_boot_flash -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_boot_flash > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: testbench/boot_checker.sv
`timescale 1ns/1ps

module boot_checker #(
    parameter int          depth_words = 1024,
    parameter logic [31:0] boot_window = 32'h0001_0000
) (
    input logic        sys,
    input logic        reset,
    input logic [31:0] console_address,
    input logic        console_ack,
    input logic [15:0] console_rdata,
    input logic        cpu_write,
    input logic [31:0] cpu_address,
    input logic [31:0] cpu_wdata,
    input logic        cpu_ack,
    input logic [31:0] cpu_rdata,
    input logic        erase_start,
    input logic        erase_busy,
    input logic        wp_enable,
    input logic        wp_disable
);

    logic [31:0] model [depth_words]; // Mirror of the flash contents
    logic        write_protect;
    int          error_count = 0;
    string       test_name = "none";

    function automatic int word_index(input logic [31:0] address);
        return int'((address >> 2) % depth_words);
    endfunction

    // Swapped halfword inside the boot window, zero outside it
    function automatic logic [15:0] expected_console(input logic [31:0] address);
        boot_pkg::flash_word_t stored;
        logic [15:0]           half;
        if (address >= boot_window) begin
            return 16'h0000;
        end
        stored.word = model[word_index(address)];
        half = stored.half[address[1]];
        return {half[7:0], half[15:8]};
    endfunction

    always @(posedge sys) begin
        if (reset) begin
            write_protect = 1'b1;
        end else begin
            if (console_ack && console_rdata !== expected_console(console_address)) begin
                $display("ERROR [%s] console read %h: expected %h, actual %h", test_name,
                         console_address, expected_console(console_address), console_rdata);
                error_count++;
            end
            if (!console_ack && console_rdata !== 16'h0000) begin
                $display("ERROR [%s] console data without ack: expected %h, actual %h",
                         test_name, 16'h0000, console_rdata);
                error_count++;
            end
            if (!cpu_ack && cpu_rdata !== 32'h0000_0000) begin
                $display("ERROR [%s] CPU data without ack: expected %h, actual %h",
                         test_name, 32'h0000_0000, cpu_rdata);
                error_count++;
            end
            if (cpu_ack && cpu_write) begin
                if (!write_protect) begin
                    model[word_index(cpu_address)] = cpu_wdata; // Protected writes leave it as is
                end
            end else if (cpu_ack && cpu_rdata !== model[word_index(cpu_address)]) begin
                $display("ERROR [%s] CPU read %h: expected %h, actual %h", test_name,
                         cpu_address, model[word_index(cpu_address)], cpu_rdata);
                error_count++;
            end
            if (console_ack && cpu_ack) begin
                $display("Both requesters were acked in the same cycle during %s", test_name);
                error_count++;
            end
            if (erase_start && !erase_busy) begin
                for (int i = 0; i < depth_words; i++) begin
                    model[i] = boot_pkg::erased_word;
                end
            end
            if (wp_enable) begin
                write_protect = 1'b1;
            end else if (wp_disable) begin
                write_protect = 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_boot_flash.sv
`timescale 1ns/1ps

module tb_boot_flash;

    localparam int          depth_words = 1024;
    localparam logic [31:0] boot_window = 32'h0001_0000;
    localparam int          ack_timeout = depth_words + 64; // Outlasts a full erase sweep
    localparam int          busy_timeout = depth_words + 16;

    logic        sys;
    logic        reset;
    logic        console_request;
    logic [31:0] console_address;
    logic        console_ack;
    logic [15:0] console_rdata;
    logic        cpu_request;
    logic        cpu_write;
    logic [31:0] cpu_address;
    logic [31:0] cpu_wdata;
    logic        cpu_ack;
    logic [31:0] cpu_rdata;
    logic        erase_start;
    logic        erase_busy;
    logic        wp_enable;
    logic        wp_disable;

    int          timeout_count = 0;
    int          order_errors = 0;
    int          total_errors;
    time         console_ack_time;
    time         cpu_ack_time;
    logic [31:0] addr_list [8];

    boot_flash_top #(.depth_words(depth_words), .boot_window(boot_window)) dut_i (.*);

    boot_checker #(.depth_words(depth_words), .boot_window(boot_window)) checker_i (.*);

    initial begin
        sys = 1'b0;
        forever #4 sys = ~sys;
    end

    task automatic console_read(input logic [31:0] address);
        int cycles;
        @(negedge sys);
        console_request = 1'b1;
        console_address = address;
        cycles = 0;
        @(negedge sys);
        while (!console_ack && cycles < ack_timeout) begin
            @(negedge sys);
            cycles++;
        end
        if (!console_ack) begin
            $display("Timeout: no console ack for address %h", address);
            timeout_count++;
        end
        console_ack_time = $time;
        console_request = 1'b0; // Address stays put until the next access
    endtask

    task automatic cpu_access(input logic is_write, input logic [31:0] address,
                              input logic [31:0] wdata);
        int cycles;
        @(negedge sys);
        cpu_request = 1'b1;
        cpu_write = is_write;
        cpu_address = address;
        cpu_wdata = wdata;
        cycles = 0;
        @(negedge sys);
        while (!cpu_ack && cycles < ack_timeout) begin
            @(negedge sys);
            cycles++;
        end
        if (!cpu_ack) begin
            $display("Timeout: no CPU ack for address %h", address);
            timeout_count++;
        end else if (erase_busy) begin
            $display("CPU access was acked while the erase was still running");
            order_errors++;
        end
        cpu_ack_time = $time;
        cpu_request = 1'b0;
    endtask

    task automatic pulse_erase();
        int cycles;
        @(negedge sys);
        erase_start = 1'b1;
        @(negedge sys);
        erase_start = 1'b0;
        cycles = 0;
        while (!erase_busy && cycles < 4) begin
            @(negedge sys);
            cycles++;
        end
        if (!erase_busy) begin
            $display("Timeout: erase_busy did not rise after erase_start");
            timeout_count++;
        end
    endtask

    task automatic wait_erase_idle();
        int cycles;
        cycles = 0;
        while (erase_busy && cycles < busy_timeout) begin
            @(negedge sys);
            cycles++;
        end
        if (erase_busy) begin
            $display("Timeout: erase_busy still high after %0d cycles", busy_timeout);
            timeout_count++;
        end
    endtask

    task automatic pulse_protect(input logic enable);
        @(negedge sys);
        wp_enable = enable;
        wp_disable = !enable;
        @(negedge sys);
        wp_enable = 1'b0;
        wp_disable = 1'b0;
    endtask

    // Random words to random addresses, then the same addresses read back
    task automatic write_then_read_back();
        for (int i = 0; i < 8; i++) begin
            addr_list[i] = $urandom % (depth_words * 4);
            cpu_access(1'b1, addr_list[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b0, addr_list[i], 32'h0);
        end
    endtask

    initial begin
        void'($urandom(32'h6759589c));
        reset = 1'b1;
        console_request = 1'b0;
        console_address = '0;
        cpu_request = 1'b0;
        cpu_write = 1'b0;
        cpu_address = '0;
        cpu_wdata = '0;
        erase_start = 1'b0;
        wp_enable = 1'b0;
        wp_disable = 1'b0;
        repeat (5) @(posedge sys);
        @(negedge sys);
        reset = 1'b0;

        checker_i.test_name = "erase";
        pulse_erase();
        wait_erase_idle();
        for (int i = 0; i < 16; i++) begin
            cpu_access(1'b0, $urandom % (depth_words * 4), 32'h0);
            console_read($urandom % boot_window);
        end

        checker_i.test_name = "write_protect";
        write_then_read_back(); // Still protected from reset
        pulse_protect(1'b0);
        write_then_read_back();

        checker_i.test_name = "console_format";
        for (int i = 0; i < 8; i++) begin
            console_read(addr_list[i]); // Freshly written words, both halves
            console_read(addr_list[i] ^ 32'h0000_0002);
        end
        console_read(boot_window - 2);
        console_read(boot_window);
        for (int i = 0; i < 32; i++) begin
            console_read($urandom % (2 * boot_window));
        end

        checker_i.test_name = "arbitration";
        fork
            console_read(addr_list[0]);
            cpu_access(1'b0, addr_list[1], 32'h0);
        join
        if (console_ack_time >= cpu_ack_time) begin
            $display("Arbitration: the CPU was acked before the console");
            order_errors++;
        end

        checker_i.test_name = "erase_request";
        pulse_erase();
        cpu_access(1'b0, addr_list[0], 32'h0);
        wait_erase_idle();

        checker_i.test_name = "reprotect";
        pulse_protect(1'b1);
        write_then_read_back();

        total_errors = checker_i.error_count + order_errors;
        $display("Errors: %0d, timeouts: %0d", total_errors, timeout_count);
        if (total_errors == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
